// ==== Bender.yml ====
package:
  name: video_controller

sources:
  # Packages first, then the blocks, then the top level.
  - rtl/bus_pkg.sv
  - rtl/video_pkg.sv
  - rtl/dual_port_ram.sv
  - rtl/cpu_bus_decoder.sv
  - rtl/line_fetcher.sv
  - rtl/pixel_lookup.sv
  - rtl/video_controller.sv

  - target: simulation
    files:
      - verif/vram_model.sv
      - verif/tb_video_controller.sv

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// ============================================================
	// Address map
	// ============================================================

	localparam logic [31:0] VRAM_LIMIT = 32'h0080_0000;
	localparam logic [31:0] PALETTE_LIMIT = 32'h0080_0400;

	typedef enum logic [1:0] {
		REGION_VRAM,
		REGION_PALETTE,
		REGION_CONTROL
	} region_t;

	// ============================================================
	// Request/ready bus
	// ============================================================

	// Rw high means write.
	typedef struct packed {
		logic request;
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_bus_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_decoder import bus_pkg::*, video_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire bus_req_t i_cpu_req,
	output bus_rsp_t o_cpu_rsp,

	output bus_req_t o_vram_a_req,
	input wire bus_rsp_t i_vram_a_rsp,

	output palette_wr_t o_palette_wr,
	output logic [31:0] o_start_address
);

	region_t region;
	logic accept;

	logic cpu_ready;
	logic [31:0] cpu_rdata;

	logic vram_pending;
	logic vram_rw;
	logic [31:0] vram_address;
	logic [31:0] vram_wdata;

	logic palette_valid;
	pixel_index_t palette_index;
	color_t palette_color;

	always_comb begin
		if (i_cpu_req.address < VRAM_LIMIT) begin
			region = REGION_VRAM;
		end else if (i_cpu_req.address < PALETTE_LIMIT) begin
			region = REGION_PALETTE;
		end else begin
			region = REGION_CONTROL;
		end
	end

	// Held request is ignored while its ready is still out.
	assign accept = i_cpu_req.request && !cpu_ready && !vram_pending;

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			cpu_ready <= 1'b0;
			vram_pending <= 1'b0;
			palette_valid <= 1'b0;
			o_start_address <= '0;
		end else begin
			cpu_ready <= 1'b0;
			palette_valid <= 1'b0;
			if (vram_pending) begin
				// Forward memory ready one cycle late.
				if (i_vram_a_rsp.ready) begin
					vram_pending <= 1'b0;
					cpu_ready <= 1'b1;
				end
			end else if (accept) begin
				case (region)
					REGION_VRAM: begin
						if (!i_vram_a_rsp.ready) begin
							vram_pending <= 1'b1;
						end
					end
					REGION_PALETTE: begin
						palette_valid <= i_cpu_req.rw;
						cpu_ready <= 1'b1;
					end
					default: begin
						if (i_cpu_req.rw) begin
							o_start_address <= i_cpu_req.wdata;
						end
						cpu_ready <= 1'b1;
					end
				endcase
			end
		end
	end

	// ============================================================
	// Payload
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (accept) begin
			vram_rw <= i_cpu_req.rw;
			vram_address <= i_cpu_req.address;
			vram_wdata <= i_cpu_req.wdata;
			palette_index <= i_cpu_req.address[9:2];
			palette_color <= i_cpu_req.wdata[23:0];
		end
		// Palette is write only and reads back as zero.
		if (vram_pending && i_vram_a_rsp.ready) begin
			cpu_rdata <= i_vram_a_rsp.rdata;
		end else if (accept) begin
			cpu_rdata <= (region == REGION_CONTROL) ? o_start_address : '0;
		end
	end

	assign o_cpu_rsp = '{ready: cpu_ready, rdata: cpu_rdata};

	assign o_vram_a_req = '{
		request: vram_pending,
		rw: vram_rw,
		address: vram_address,
		wdata: vram_wdata
	};

	assign o_palette_wr = '{valid: palette_valid, index: palette_index, color: palette_color};

endmodule

`default_nettype wire

// ==== rtl/dual_port_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_port_ram #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 256
) (
	input wire logic i_clock,

	input wire logic i_wr_en,
	input wire logic [$clog2(DEPTH)-1:0] i_wr_addr,
	input wire payload_t i_wr_data,

	input wire logic [$clog2(DEPTH)-1:0] i_rd_addr,
	output payload_t o_rd_data
);

	payload_t mem [DEPTH];

	// Write port.
	always_ff @(posedge i_clock) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// Read port, one cycle of latency.
	always_ff @(posedge i_clock) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// ==== rtl/line_fetcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_fetcher import bus_pkg::*, video_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire logic i_hblank,
	input wire logic i_vblank,
	input wire logic [31:0] i_start_address,

	output bus_req_t o_vram_b_req,
	input wire bus_rsp_t i_vram_b_rsp,

	output line_wr_t o_line_wr,
	output logic o_front_bank
);

	typedef enum logic [1:0] {
		WAIT_BLANK,
		WAIT_MEMORY,
		WAIT_DELAY
	} fetch_state_t;

	fetch_state_t state;

	logic [2:0] hblank_sync;
	logic [2:0] vblank_sync;
	logic hblank_fall;
	logic vblank_fall;
	logic visible;
	logic hblank_event;
	logic vblank_event;

	logic skip;
	logic vram_req;
	logic [31:0] vram_address;
	logic [31:0] row_address;
	logic [LINE_ADDR_W-1:0] word_index;
	logic word_accept;
	logic fetch_done;

	// ============================================================
	// Blank synchronizers and edge detect
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			hblank_sync <= '0;
			vblank_sync <= '0;
		end else begin
			hblank_sync <= {hblank_sync[1:0], i_hblank};
			vblank_sync <= {vblank_sync[1:0], i_vblank};
		end
	end

	assign hblank_fall = hblank_sync[2] && !hblank_sync[1];
	assign vblank_fall = vblank_sync[2] && !vblank_sync[1];
	assign visible = vblank_sync[1];

	assign word_accept = (state == WAIT_MEMORY) && i_vram_b_rsp.ready;
	assign fetch_done = word_accept && (word_index == LINE_ADDR_W'(LINE_WORDS - 1));

	// ============================================================
	// Fetch FSM
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= WAIT_BLANK;
			vram_req <= 1'b0;
			hblank_event <= 1'b0;
			vblank_event <= 1'b0;
			skip <= 1'b0;
			o_front_bank <= 1'b0;
		end else begin
			case (state)
				WAIT_BLANK: begin
					// Previous ready must be gone first.
					if (!i_vram_b_rsp.ready) begin
						if (vblank_event) begin
							vram_address <= i_start_address;
							row_address <= i_start_address;
							word_index <= '0;
							vram_req <= 1'b1;
							state <= WAIT_MEMORY;
							vblank_event <= 1'b0;
							hblank_event <= 1'b0;
							skip <= 1'b1;
						end else if (hblank_event) begin
							hblank_event <= 1'b0;
							if (visible) begin
								// Each source row is shown twice.
								if (skip) begin
									vram_address <= row_address + PPITCH;
									row_address <= row_address + PPITCH;
									word_index <= '0;
									vram_req <= 1'b1;
									state <= WAIT_MEMORY;
								end
								skip <= !skip;
							end
						end
					end
				end
				WAIT_MEMORY: begin
					if (i_vram_b_rsp.ready) begin
						vram_req <= 1'b0;
						word_index <= word_index + 1'b1;
						state <= fetch_done ? WAIT_BLANK : WAIT_DELAY;
					end
				end
				WAIT_DELAY: begin
					if (!i_vram_b_rsp.ready) begin
						vram_address <= vram_address + 32'd4;
						vram_req <= 1'b1;
						state <= WAIT_MEMORY;
					end
				end
				default: begin
					state <= WAIT_BLANK;
				end
			endcase

			if (fetch_done) begin
				o_front_bank <= !o_front_bank;
			end
			// A new edge wins over a consume in the same cycle.
			if (hblank_fall) begin
				hblank_event <= 1'b1;
			end
			if (vblank_fall) begin
				vblank_event <= 1'b1;
			end
		end
	end

	assign o_vram_b_req = '{
		request: vram_req,
		rw: 1'b0,
		address: vram_address,
		wdata: '0
	};

	// Returned words go straight to the back bank.
	assign o_line_wr = '{
		valid: word_accept,
		bank: !o_front_bank,
		word: word_index,
		data: i_vram_b_rsp.rdata
	};

endmodule

`default_nettype wire

// ==== rtl/pixel_lookup.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_lookup import video_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire logic [9:0] i_pos_x,
	input wire logic i_front_bank,

	input wire line_word_t i_bank_data [BANK_COUNT],
	output logic [LINE_ADDR_W-1:0] o_bank_addr,

	output pixel_index_t o_palette_addr,
	input wire color_t i_palette_color,

	output color_t o_video_rgb
);

	logic [1:0] byte_sel;
	logic bank_sel;
	line_word_t front_word;

	// Four pixels per word.
	assign o_bank_addr = i_pos_x[LINE_ADDR_W+1:2];

	// Aligned with the bank read data.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			byte_sel <= '0;
			bank_sel <= 1'b0;
		end else begin
			byte_sel <= i_pos_x[1:0];
			bank_sel <= i_front_bank;
		end
	end

	assign front_word = i_bank_data[bank_sel];

	// Byte 0 is the leftmost pixel.
	assign o_palette_addr = front_word[{byte_sel, 3'b000} +: 8];

	assign o_video_rgb = i_palette_color;

endmodule

`default_nettype wire

// ==== rtl/video_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_controller import bus_pkg::*, video_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire bus_req_t i_cpu_req,
	output bus_rsp_t o_cpu_rsp,

	input wire logic i_video_hblank,
	input wire logic i_video_vblank,
	input wire logic [9:0] i_video_pos_x,
	input wire logic [9:0] i_video_pos_y,
	output color_t o_video_rgb,

	output bus_req_t o_vram_a_req,
	input wire bus_rsp_t i_vram_a_rsp,
	output bus_req_t o_vram_b_req,
	input wire bus_rsp_t i_vram_b_rsp
);

	// Rows follow blank events, so pos_y is not needed here.

	palette_wr_t palette_wr;
	logic [31:0] start_address;
	line_wr_t line_wr;
	logic front_bank;

	line_word_t bank_data [BANK_COUNT];
	logic [LINE_ADDR_W-1:0] bank_addr;
	pixel_index_t palette_addr;
	color_t palette_color;

	// ============================================================
	// CPU side
	// ============================================================

	cpu_bus_decoder u_cpu_bus_decoder (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_req(i_cpu_req),
		.o_cpu_rsp(o_cpu_rsp),
		.o_vram_a_req(o_vram_a_req),
		.i_vram_a_rsp(i_vram_a_rsp),
		.o_palette_wr(palette_wr),
		.o_start_address(start_address)
	);

	dual_port_ram #(
		.payload_t(color_t),
		.DEPTH(PALETTE_DEPTH)
	) u_palette (
		.i_clock(i_clock),
		.i_wr_en(palette_wr.valid),
		.i_wr_addr(palette_wr.index),
		.i_wr_data(palette_wr.color),
		.i_rd_addr(palette_addr),
		.o_rd_data(palette_color)
	);

	// ============================================================
	// Video side
	// ============================================================

	line_fetcher u_line_fetcher (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_hblank(i_video_hblank),
		.i_vblank(i_video_vblank),
		.i_start_address(start_address),
		.o_vram_b_req(o_vram_b_req),
		.i_vram_b_rsp(i_vram_b_rsp),
		.o_line_wr(line_wr),
		.o_front_bank(front_bank)
	);

	// Ping-pong line banks.
	for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
		logic bank_wr_en;

		assign bank_wr_en = line_wr.valid && (line_wr.bank == 1'(b));

		dual_port_ram #(
			.payload_t(line_word_t),
			.DEPTH(LINE_WORDS)
		) u_line_bank (
			.i_clock(i_clock),
			.i_wr_en(bank_wr_en),
			.i_wr_addr(line_wr.word),
			.i_wr_data(line_wr.data),
			.i_rd_addr(bank_addr),
			.o_rd_data(bank_data[b])
		);
	end

	pixel_lookup u_pixel_lookup (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_pos_x(i_video_pos_x),
		.i_front_bank(front_bank),
		.i_bank_data(bank_data),
		.o_bank_addr(bank_addr),
		.o_palette_addr(palette_addr),
		.i_palette_color(palette_color),
		.o_video_rgb(o_video_rgb)
	);

endmodule

`default_nettype wire

// ==== rtl/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// Source row geometry, 320 indexed pixels per row.
	localparam int PPITCH = 320;
	localparam int LINE_WORDS = PPITCH / 4;
	localparam int LINE_ADDR_W = $clog2(LINE_WORDS);

	// Two line banks, one shown while the other fills.
	localparam int BANK_COUNT = 2;

	localparam int PALETTE_DEPTH = 256;

	typedef logic [23:0] color_t;
	typedef logic [7:0] pixel_index_t;
	typedef logic [31:0] line_word_t;

	typedef struct packed {
		logic valid;
		pixel_index_t index;
		color_t color;
	} palette_wr_t;

	// One fetched word on its way into a line bank.
	typedef struct packed {
		logic valid;
		logic bank;
		logic [LINE_ADDR_W-1:0] word;
		line_word_t data;
	} line_wr_t;

endpackage

`default_nettype wire

// ==== verif/tb_video_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_video_controller import bus_pkg::*, video_pkg::*; ();

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY = 1;

	localparam int VRAM_WORDS = 16384;
	localparam int VRAM_INDEX_BITS = $clog2(VRAM_WORDS);
	localparam int MAX_LATENCY = 3;

	// Worst case for one word: issue, latency, ready, drop, ready low.
	localparam int WORD_CYCLES_MAX = MAX_LATENCY + 5;
	localparam int TIMEOUT_CYCLES = 4 * LINE_WORDS * WORD_CYCLES_MAX
		+ 8 * PALETTE_DEPTH + 4 * PPITCH + 1000;

	localparam int HBLANK_CYCLES = 4;
	localparam int SKIP_SETTLE_CYCLES = 16;

	localparam logic [31:0] PALETTE_BASE = VRAM_LIMIT;
	localparam logic [31:0] CONTROL_ADDRESS = PALETTE_LIMIT;
	localparam logic [31:0] START_ADDRESS = 32'h0000_2a40;
	localparam logic [31:0] VRAM_TEST_ADDRESS = 32'h0000_0100;

	logic clock = 1'b0;
	logic rst_n;
	bus_req_t cpu_req;
	bus_rsp_t cpu_rsp;
	logic video_hblank;
	logic video_vblank;
	logic [9:0] pos_x;
	logic [9:0] pos_y;
	color_t video_rgb;
	bus_req_t vram_a_req;
	bus_rsp_t vram_a_rsp;
	bus_req_t vram_b_req;
	bus_rsp_t vram_b_rsp;

	logic a_request;
	logic a_ready;
	logic b_request;
	logic b_ready;

	logic [31:0] vram_image [VRAM_WORDS];
	color_t palette [PALETTE_DEPTH];
	logic [31:0] expected_row = '0;

	logic pixel_check = 1'b0;
	logic check_d1 = 1'b0;
	logic check_d2 = 1'b0;
	logic [9:0] x_d1 = '0;
	logic [9:0] x_d2 = '0;

	int mismatch_count = 0;
	int failure_count = 0;
	int cycle_count = 0;

	assign a_request = vram_a_req.request;
	assign a_ready = vram_a_rsp.ready;
	assign b_request = vram_b_req.request;
	assign b_ready = vram_b_rsp.ready;

	video_controller DUT (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_cpu_req(cpu_req),
		.o_cpu_rsp(cpu_rsp),
		.i_video_hblank(video_hblank),
		.i_video_vblank(video_vblank),
		.i_video_pos_x(pos_x),
		.i_video_pos_y(pos_y),
		.o_video_rgb(video_rgb),
		.o_vram_a_req(vram_a_req),
		.i_vram_a_rsp(vram_a_rsp),
		.o_vram_b_req(vram_b_req),
		.i_vram_b_rsp(vram_b_rsp)
	);

	vram_model #(
		.WORDS(VRAM_WORDS),
		.MAX_LATENCY(MAX_LATENCY)
	) u_vram (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_a_req(vram_a_req),
		.o_a_rsp(vram_a_rsp),
		.i_b_req(vram_b_req),
		.o_b_rsp(vram_b_rsp)
	);

	always #(CLOCK_PERIOD / 2) clock = !clock;

	// Pixel position and check enable, aligned with the 2 cycle lookup.
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		x_d1 <= pos_x;
		x_d2 <= x_d1;
		check_d1 <= pixel_check;
		check_d2 <= check_d1;
	end

	// Palette entry for byte x mod 4 of the row word at x div 4.
	function automatic color_t expected_rgb(input logic [9:0] x);
		logic [31:0] address;
		logic [31:0] word;
		pixel_index_t index;
		address = expected_row + 32'(4 * (x / 4));
		word = vram_image[address[VRAM_INDEX_BITS+1:2]];
		index = word[8 * (x % 4) +: 8];
		return palette[index];
	endfunction

	// ============================================================
	// Assertions
	// ============================================================

	a_port_a_mirror: assert property (@(posedge clock) disable iff (!rst_n)
		a_request |-> (vram_a_req.address == cpu_req.address
			&& vram_a_req.wdata == cpu_req.wdata && vram_a_req.rw == cpu_req.rw))
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: port A request differs from the CPU request", $time);
	end

	a_reset_idle: assert property (@(posedge clock)
		$rose(rst_n) |-> (!a_request && !b_request))
	else begin
		failure_count++;
		$display("VRAM request was high right after reset at %0t", $time);
	end

	a_port_a_hygiene: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(a_request) |-> !$past(a_ready))
	else begin
		failure_count++;
		$display("Port A raised a new request at %0t before ready dropped", $time);
	end

	a_port_b_hygiene: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(b_request) |-> !$past(b_ready))
	else begin
		failure_count++;
		$display("Port B raised a new request at %0t before ready dropped", $time);
	end

	a_pixel: assert property (@(posedge clock) disable iff (!rst_n)
		check_d2 |-> (video_rgb == expected_rgb(x_d2)))
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: pixel x=%0d shows %h, expected %h", $time,
			$sampled(x_d2), $sampled(video_rgb), expected_rgb($sampled(x_d2)));
	end

	// ============================================================
	// Stimulus tasks
	// ============================================================

	task automatic next_cycle();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic cpu_access(input logic rw, input logic [31:0] address,
			input logic [31:0] wdata, output logic [31:0] rdata);
		cpu_req = '{request: 1'b1, rw: rw, address: address, wdata: wdata};
		do begin
			next_cycle();
		end while (!cpu_rsp.ready);
		rdata = cpu_rsp.rdata;
		cpu_req.request = 1'b0;
	endtask

	task automatic expect_read(input logic [31:0] address, input logic [31:0] expected,
			input string what);
		logic [31:0] data;
		cpu_access(1'b0, address, 32'h0, data);
		assert (data == expected) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s read %h, expected %h", $time, what, data, expected);
		end
	endtask

	task automatic fill_vram();
		logic [31:0] word;
		int i;
		for (i = 0; i < VRAM_WORDS; i++) begin
			word = $urandom;
			vram_image[i] = word;
			u_vram.load_word(i, word);
		end
	endtask

	task automatic load_palette();
		color_t color;
		logic [31:0] unused;
		int i;
		for (i = 0; i < PALETTE_DEPTH; i++) begin
			color = color_t'($urandom);
			palette[i] = color;
			cpu_access(1'b1, PALETTE_BASE + 32'(4 * i), {8'h00, color}, unused);
		end
	endtask

	task automatic pulse_hblank();
		video_hblank = 1'b1;
		repeat (HBLANK_CYCLES) next_cycle();
		video_hblank = 1'b0;
	endtask

	task automatic wait_row_fetch(input logic [31:0] row_address);
		int i;
		while (u_vram.b_done < LINE_WORDS) begin
			next_cycle();
		end
		while (b_request || b_ready) begin
			next_cycle();
		end
		assert (u_vram.b_log.size() == LINE_WORDS) else begin
			mismatch_count++;
			$display("Mismatch at %0t: row fetch issued %0d reads, expected %0d",
				$time, u_vram.b_log.size(), LINE_WORDS);
		end
		for (i = 0; i < u_vram.b_log.size(); i++) begin
			assert (u_vram.b_log[i] == row_address + 32'(4 * i)) else begin
				mismatch_count++;
				$display("Mismatch at %0t: port B read %0d at %h, expected %h", $time,
					i, u_vram.b_log[i], row_address + 32'(4 * i));
			end
		end
	endtask

	task automatic expect_no_fetch();
		repeat (SKIP_SETTLE_CYCLES) next_cycle();
		assert (u_vram.b_log.size() == 0) else begin
			mismatch_count++;
			$display("Mismatch at %0t: port B fetched a row on a skipped hblank", $time);
		end
	endtask

	task automatic scan_line(input logic [31:0] row_address);
		int x;
		expected_row = row_address;
		pixel_check = 1'b1;
		for (x = 0; x < PPITCH; x++) begin
			pos_x = 10'(x);
			next_cycle();
		end
		pixel_check = 1'b0;
		repeat (3) next_cycle();
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [31:0] data;
		logic [31:0] unused;
		logic [31:0] row;
		int h;
		void'($urandom(32'hc207_b65e));
		rst_n = 1'b0;
		cpu_req = '0;
		video_hblank = 1'b0;
		video_vblank = 1'b1;
		pos_x = '0;
		pos_y = '0;
		fill_vram();
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		next_cycle();

		data = $urandom;
		cpu_access(1'b1, VRAM_TEST_ADDRESS, data, unused);
		vram_image[VRAM_TEST_ADDRESS[VRAM_INDEX_BITS+1:2]] = data;
		expect_read(VRAM_TEST_ADDRESS, data, "VRAM");

		load_palette();
		expect_read(PALETTE_BASE + 32'h4, 32'h0, "palette");
		cpu_access(1'b1, CONTROL_ADDRESS, START_ADDRESS, unused);
		expect_read(CONTROL_ADDRESS, START_ADDRESS, "start address");

		// Falling vblank starts the frame at the start address.
		row = START_ADDRESS;
		u_vram.clear_log();
		video_vblank = 1'b0;
		wait_row_fetch(row);
		video_vblank = 1'b1;
		scan_line(row);

		for (h = 0; h < 4; h++) begin
			u_vram.clear_log();
			pulse_hblank();
			if (h % 2 == 0) begin
				row = row + PPITCH;
				wait_row_fetch(row);
				scan_line(row);
			end else begin
				expect_no_fetch();
			end
		end

		$display("Errors: %0d mismatches, %0d protocol failures", mismatch_count,
			failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/vram_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module vram_model import bus_pkg::*; #(
	parameter int WORDS = 16384,
	parameter int MAX_LATENCY = 3
) (
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire bus_req_t i_a_req,
	output bus_rsp_t o_a_rsp,

	input wire bus_req_t i_b_req,
	output bus_rsp_t o_b_rsp
);

	logic [31:0] mem [WORDS];

	bus_req_t req [2];
	bus_rsp_t rsp [2];
	logic waiting [2];
	int unsigned delay [2];

	// Port B read addresses, in issue order.
	logic [31:0] b_log [$];
	int b_done = 0;

	assign req[0] = i_a_req;
	assign req[1] = i_b_req;
	assign o_a_rsp = rsp[0];
	assign o_b_rsp = rsp[1];

	function automatic int word_index(input logic [31:0] address);
		return int'(address[$clog2(WORDS)+1:2]);
	endfunction

	function void load_word(input int index, input logic [31:0] data);
		mem[index] = data;
	endfunction

	function void clear_log();
		b_log.delete();
		b_done = 0;
	endfunction

	// ============================================================
	// Request/ready service, random latency per access
	// ============================================================

	always @(posedge i_clock) begin : serve_ports
		int p;
		for (p = 0; p < 2; p++) begin
			if (!i_rst_n || !req[p].request) begin
				rsp[p] <= '0;
				waiting[p] <= 1'b0;
			end else if (!rsp[p].ready) begin
				if (!waiting[p]) begin
					waiting[p] <= 1'b1;
					delay[p] <= $urandom_range(MAX_LATENCY, 0);
					if (p == 1) begin
						b_log.push_back(req[p].address);
					end
				end else if (delay[p] != 0) begin
					delay[p] <= delay[p] - 1;
				end else begin
					waiting[p] <= 1'b0;
					rsp[p].ready <= 1'b1;
					if (req[p].rw) begin
						mem[word_index(req[p].address)] = req[p].wdata;
					end else begin
						rsp[p].rdata <= mem[word_index(req[p].address)];
					end
					if (p == 1) begin
						b_done = b_done + 1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== video_controller.f ====
rtl/bus_pkg.sv
rtl/video_pkg.sv
rtl/dual_port_ram.sv
rtl/cpu_bus_decoder.sv
rtl/line_fetcher.sv
rtl/pixel_lookup.sv
rtl/video_controller.sv
verif/vram_model.sv
verif/tb_video_controller.sv
